// ==== src/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// user text segment, reset pc is the lowest legal address
`define TEXT_START_ADDR  32'h0000_3000
// first byte past user text
`define TEXT_END_ADDR    32'h0000_7000

// kernel entry point, the word just below it is the terminal pc
`define KTEXT_START_ADDR 32'h0000_4180

// address error on load or fetch
`define EXC_ADEL         5'd4

// primary opcode field, instr[31:26]
`define OP_SPECIAL       6'b000000
`define OP_REGIMM        6'b000001
`define OP_J             6'b000010
`define OP_JAL           6'b000011
`define OP_BEQ           6'b000100
`define OP_BNE           6'b000101
`define OP_BLEZ          6'b000110
`define OP_BGTZ          6'b000111

// funct field under SPECIAL, instr[5:0]
`define FUNCT_JR         6'b001000
`define FUNCT_JALR       6'b001001

`endif

// ==== src/fetchPkg.sv ====
package fetchPkg;

    // byte address
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] word_t;

    // exception code, zero means none
    typedef logic [4:0] excCode_t;

    // redirect request from CP0
    typedef enum logic [1:0] {
        KCTRL_NONE  = 2'd0,
        KCTRL_KTEXT = 2'd1,
        KCTRL_ERET  = 2'd2
    } kctrl_e;

    // control-flow class of the instruction in ID
    typedef enum logic [1:0] {
        FLOW_ORDER    = 2'd0,
        FLOW_BRANCH   = 2'd1,
        FLOW_JUMP_IMM = 2'd2,
        FLOW_JUMP_REG = 2'd3
    } flowClass_e;

    // decode to next-pc unit, 44 bits
    typedef struct packed {
        flowClass_e  cls;
        logic [15:0] offset;
        logic [25:0] index;
    } flowInfo_t;

    // one IF/ID slot, 70 bits
    typedef struct packed {
        word_t    code;
        addr_t    pc;
        excCode_t exc;
        logic     bd;
    } ifIdBundle_t;

endpackage

// ==== src/instrClassifier.sv ====
`timescale 1ns/1ns
`include "fetch_defines.svh"

module instrClassifier (
    input  fetchPkg::word_t     instr,
    output fetchPkg::flowInfo_t flow,
    output logic                isCtrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    fetchPkg::flowClass_e cls;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // class from opcode, funct only matters under SPECIAL
    always_comb begin
        cls = fetchPkg::FLOW_ORDER;
        case (opcode)
            `OP_BEQ,
            `OP_BNE,
            `OP_BLEZ,
            `OP_BGTZ,
            `OP_REGIMM: begin
                cls = fetchPkg::FLOW_BRANCH;
            end
            `OP_J,
            `OP_JAL: begin
                cls = fetchPkg::FLOW_JUMP_IMM;
            end
            `OP_SPECIAL: begin
                if (funct == `FUNCT_JR || funct == `FUNCT_JALR) begin
                    cls = fetchPkg::FLOW_JUMP_REG;
                end
            end
            default: begin
                cls = fetchPkg::FLOW_ORDER;
            end
        endcase
    end

    // immediate fields are extracted regardless of class
    always_comb begin
        flow.cls    = cls;
        flow.offset = instr[15:0];
        flow.index  = instr[25:0];
    end

    // anything but sequential flow puts the IF instruction in a delay slot
    assign isCtrl = (cls != fetchPkg::FLOW_ORDER);

endmodule

// ==== src/nextPcUnit.sv ====
`timescale 1ns/1ns
`include "fetch_defines.svh"

module nextPcUnit (
    input  fetchPkg::addr_t     pc,
    input  fetchPkg::flowInfo_t flow,
    input  logic                cmp,
    input  fetchPkg::addr_t     jmpReg,
    input  fetchPkg::kctrl_e    kCtrl,
    input  fetchPkg::addr_t     epc,
    output fetchPkg::addr_t     nextPc
);

    fetchPkg::addr_t seqPc;
    fetchPkg::addr_t branchTarget;
    fetchPkg::addr_t jumpTarget;
    fetchPkg::addr_t eretTarget;
    logic            terminal;

    assign seqPc = pc + 32'd4;

    // pc already points at the delay slot when the branch is in ID
    assign branchTarget = pc + {{14{flow.offset[15]}}, flow.offset, 2'b00};

    // region jump keeps the top nibble of the delay-slot pc
    assign jumpTarget = {pc[31:28], flow.index, 2'b00};

    // epc is forced to a word boundary
    assign eretTarget = {epc[31:2], 2'b00};

    // last word before kernel text, the program parks here
    assign terminal = (pc == (`KTEXT_START_ADDR - 32'd4));

    always_comb begin
        if (kCtrl == fetchPkg::KCTRL_KTEXT) begin
            nextPc = `KTEXT_START_ADDR;
        end else if (kCtrl == fetchPkg::KCTRL_ERET) begin
            nextPc = eretTarget;
        end else if (terminal) begin
            nextPc = pc;
        end else begin
            case (flow.cls)
                fetchPkg::FLOW_BRANCH: begin
                    // not taken falls through to pc + 4
                    nextPc = cmp ? branchTarget : seqPc;
                end
                fetchPkg::FLOW_JUMP_REG: begin
                    nextPc = jmpReg;
                end
                fetchPkg::FLOW_JUMP_IMM: begin
                    nextPc = jumpTarget;
                end
                default: begin
                    nextPc = seqPc;
                end
            endcase
        end
    end

endmodule

// ==== src/pcRegister.sv ====
`timescale 1ns/1ns
`include "fetch_defines.svh"

module pcRegister (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stallPc,
    input  fetchPkg::addr_t     nextPc,
    output fetchPkg::addr_t     pc,
    output fetchPkg::excCode_t  pcExc
);

    logic inText;
    logic misaligned;

    // load on every edge unless the hazard unit holds the pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `TEXT_START_ADDR;
        end else if (!stallPc) begin
            pc <= nextPc;
        end
    end

    // fetch must stay inside user text
    assign inText = (pc >= `TEXT_START_ADDR) && (pc < `TEXT_END_ADDR);

    // word fetch only
    assign misaligned = (pc[1:0] != 2'b00);

    assign pcExc = (!inText || misaligned) ? `EXC_ADEL : 5'd0;

endmodule

// ==== src/ifIdRegister.sv ====
`timescale 1ns/1ns

module ifIdRegister (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  clr,
    input  fetchPkg::ifIdBundle_t slotIf,
    output fetchPkg::ifIdBundle_t slotId
);

    // flush beats stall, an empty slot is all zeros
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slotId <= '0;
        end else if (clr) begin
            slotId <= '0;
        end else if (!stall) begin
            slotId <= slotIf;
        end
    end

endmodule

// ==== src/fetchTop.sv ====
`timescale 1ns/1ns

module fetchTop (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                stallPc,
    input  logic                clr,
    input  logic                cmp,
    input  fetchPkg::addr_t     jmpReg,
    input  fetchPkg::kctrl_e    kCtrl,
    input  fetchPkg::addr_t     epc,
    input  fetchPkg::word_t     imCode,
    output fetchPkg::addr_t     imPc,
    output fetchPkg::addr_t     pcIf,
    output logic                bdIf,
    output fetchPkg::word_t     codeId,
    output fetchPkg::addr_t     pcId,
    output fetchPkg::excCode_t  excId,
    output logic                bdId
);

    fetchPkg::addr_t       pc;
    fetchPkg::addr_t       nextPc;
    fetchPkg::excCode_t    pcExc;
    fetchPkg::flowInfo_t   flow;
    fetchPkg::ifIdBundle_t slotIf;
    fetchPkg::ifIdBundle_t slotId;
    logic                  isCtrl;

    // decode looks at the instruction currently held in ID
    instrClassifier u_classifier (
        .instr  (slotId.code),
        .flow   (flow),
        .isCtrl (isCtrl)
    );

    nextPcUnit u_nextPc (
        .pc     (pc),
        .flow   (flow),
        .cmp    (cmp),
        .jmpReg (jmpReg),
        .kCtrl  (kCtrl),
        .epc    (epc),
        .nextPc (nextPc)
    );

    pcRegister u_pcReg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stallPc (stallPc),
        .nextPc  (nextPc),
        .pc      (pc),
        .pcExc   (pcExc)
    );

    // IF side of the slot, bd marks a delay-slot fetch
    assign slotIf = '{code: imCode, pc: pc, exc: pcExc, bd: isCtrl};

    ifIdRegister u_ifId (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .clr    (clr),
        .slotIf (slotIf),
        .slotId (slotId)
    );

    // instruction memory sees the pc with no delay
    assign imPc = pc;
    assign pcIf = pc;
    assign bdIf = isCtrl;

    assign codeId = slotId.code;
    assign pcId   = slotId.pc;
    assign excId  = slotId.exc;
    assign bdId   = slotId.bd;

endmodule

// ==== verification/fetch_checker.sv ====
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetchChecker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  stallPc,
    input logic                  clr,
    input fetchPkg::addr_t       pc,
    input fetchPkg::ifIdBundle_t slotId,
    input fetchPkg::excCode_t    excId
);

    int   assertFails;
    logic pcIdIllegal;

    initial begin
        assertFails = 0;
    end

    // pc held in ID lies outside user text or off a word boundary
    assign pcIdIllegal = (slotId.pc < `TEXT_START_ADDR) || (slotId.pc >= `TEXT_END_ADDR)
                         || (slotId.pc[1:0] != 2'b00);

    // hazard unit freezes the pc
    pcHold: assert property (@(posedge clk) disable iff (!rst_n) stallPc |=> $stable(pc))
        else begin
            $error("pc changed while stallPc was high");
            assertFails++;
        end

    // flushed slot is empty
    slotFlush: assert property (@(posedge clk) disable iff (!rst_n) clr |=> (slotId == '0))
        else begin
            $error("IF/ID slot not zero after clr");
            assertFails++;
        end

    // occupied slot carries ADEL exactly for an illegal pc
    excLegal: assert property (@(posedge clk) disable iff (!rst_n)
        (slotId != '0) |-> (excId == (pcIdIllegal ? `EXC_ADEL : 5'd0)))
        else begin
            $error("excId does not match the legality of pcId");
            assertFails++;
        end

endmodule

bind fetchTop fetchChecker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .stallPc (stallPc),
    .clr     (clr),
    .pc      (pc),
    .slotId  (slotId),
    .excId   (excId)
);

// ==== verification/fetchTb.sv ====
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetchTb;

    typedef struct packed {
        logic               stall;
        logic               stallPc;
        logic               clr;
        logic               cmp;
        fetchPkg::kctrl_e   kCtrl;
        fetchPkg::addr_t    epc;
        fetchPkg::addr_t    jmpReg;
        fetchPkg::word_t    instr;
        fetchPkg::addr_t    expPcIf;
        fetchPkg::addr_t    expPcId;
        fetchPkg::excCode_t expExc;
        logic               expBd;
    } stepRow_t;

    logic clk;
    logic rst_n;
    logic stall;
    logic stallPc;
    logic clr;
    logic cmp;
    fetchPkg::addr_t    jmpReg;
    fetchPkg::kctrl_e   kCtrl;
    fetchPkg::addr_t    epc;
    fetchPkg::word_t    imCode;
    fetchPkg::addr_t    imPc;
    fetchPkg::addr_t    pcIf;
    logic               bdIf;
    fetchPkg::word_t    codeId;
    fetchPkg::addr_t    pcId;
    fetchPkg::excCode_t excId;
    logic               bdId;

    // sparse instruction memory with NOP in unwritten words
    fetchPkg::word_t imem [fetchPkg::addr_t];
    int              memWrites;

    stepRow_t              rows [$];
    fetchPkg::addr_t       refPc;
    fetchPkg::ifIdBundle_t refSlot;

    fetchTop u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .stallPc (stallPc),
        .clr     (clr),
        .cmp     (cmp),
        .jmpReg  (jmpReg),
        .kCtrl   (kCtrl),
        .epc     (epc),
        .imCode  (imCode),
        .imPc    (imPc),
        .pcIf    (pcIf),
        .bdIf    (bdIf),
        .codeId  (codeId),
        .pcId    (pcId),
        .excId   (excId),
        .bdId    (bdId)
    );

    always #50 clk = ~clk;

    // combinational read that also follows memory writes
    always @(imPc or memWrites) begin
        imCode = imem.exists(imPc) ? imem[imPc] : 32'h0;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            abortRun("a checked value differed from its expected value");
        end
    endtask

    task automatic waitForPcIf(input fetchPkg::addr_t target, input int limit);
        int n;
        n = 0;
        while (pcIf !== target && n < limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (pcIf !== target) begin
            abortRun($sformatf("timed out waiting for pcIf to reach %h", target));
        end
    endtask

    function automatic fetchPkg::flowClass_e flowOf(input fetchPkg::word_t w);
        case (w[31:26])
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM: return fetchPkg::FLOW_BRANCH;
            `OP_J, `OP_JAL: return fetchPkg::FLOW_JUMP_IMM;
            `OP_SPECIAL: begin
                if (w[5:0] == `FUNCT_JR || w[5:0] == `FUNCT_JALR) begin
                    return fetchPkg::FLOW_JUMP_REG;
                end
                return fetchPkg::FLOW_ORDER;
            end
            default: return fetchPkg::FLOW_ORDER;
        endcase
    endfunction

    function automatic fetchPkg::excCode_t excOf(input fetchPkg::addr_t a);
        if (a < `TEXT_START_ADDR || a >= `TEXT_END_ADDR || a[1:0] != 2'b00) begin
            return `EXC_ADEL;
        end
        return 5'd0;
    endfunction

    // reference next pc from the word held in ID
    function automatic fetchPkg::addr_t refNextPc(input fetchPkg::addr_t pc,
                                                  input fetchPkg::word_t idCode,
                                                  input logic cmpIn,
                                                  input fetchPkg::addr_t jr,
                                                  input fetchPkg::kctrl_e k,
                                                  input fetchPkg::addr_t e);
        fetchPkg::flowClass_e cls;
        logic [31:0]          offs;
        cls  = flowOf(idCode);
        offs = {{16{idCode[15]}}, idCode[15:0]};
        if (k == fetchPkg::KCTRL_KTEXT) return `KTEXT_START_ADDR;
        if (k == fetchPkg::KCTRL_ERET) return e & ~32'h3;
        if (pc == `KTEXT_START_ADDR - 32'd4) return pc;
        if (cls == fetchPkg::FLOW_BRANCH && cmpIn) return pc + offs * 4;
        if (cls == fetchPkg::FLOW_JUMP_REG) return jr;
        if (cls == fetchPkg::FLOW_JUMP_IMM) return {pc[31:28], idCode[25:0], 2'b00};
        return pc + 32'd4;
    endfunction

    task automatic addRow(input logic st, input logic sp, input logic cl, input logic cm,
                          input logic [1:0] k, input fetchPkg::addr_t e,
                          input fetchPkg::addr_t jr, input fetchPkg::word_t ins,
                          input fetchPkg::addr_t pIf, input fetchPkg::addr_t pId,
                          input fetchPkg::excCode_t ex, input logic bd);
        stepRow_t r;
        r.stall   = st;
        r.stallPc = sp;
        r.clr     = cl;
        r.cmp     = cm;
        r.kCtrl   = fetchPkg::kctrl_e'(k);
        r.epc     = e;
        r.jmpReg  = jr;
        r.instr   = ins;
        r.expPcIf = pIf;
        r.expPcId = pId;
        r.expExc  = ex;
        r.expBd   = bd;
        rows.push_back(r);
    endtask

    // a zero jmpReg gets a random value since no register jump sits in ID
    task automatic buildTable();
        // st sp cl cm k  epc  jmpReg  instr  pcIf  pcId  exc bd
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000001, 32'h3004, 32'h3000, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000002, 32'h3008, 32'h3004, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000003, 32'h300C, 32'h3008, 0, 0);
        addRow(1, 1, 0, 0, 0, 32'h0, 32'h0, 32'h24000004, 32'h300C, 32'h3008, 0, 0);
        addRow(1, 1, 0, 0, 0, 32'h0, 32'h0, 32'h24000004, 32'h300C, 32'h3008, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000004, 32'h3010, 32'h300C, 0, 0);
        addRow(0, 0, 1, 0, 0, 32'h0, 32'h0, 32'h24000005, 32'h3014, 32'h0000, 0, 0);
        // beq +3 taken, then beq +2 not taken
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h10000003, 32'h3018, 32'h3014, 0, 0);
        addRow(0, 0, 0, 1, 0, 32'h0, 32'h0, 32'h24000006, 32'h3024, 32'h3018, 0, 1);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h10000002, 32'h3028, 32'h3024, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000007, 32'h302C, 32'h3028, 0, 1);
        // j 0x3100, then jr to 0x3200
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h08000C40, 32'h3030, 32'h302C, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000008, 32'h3100, 32'h3030, 0, 1);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h03E00008, 32'h3104, 32'h3100, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h3200, 32'h24000009, 32'h3200, 32'h3104, 0, 1);
        // kernel entry and eret with an unaligned epc
        addRow(0, 0, 0, 0, 1, 32'h0, 32'h0, 32'h2400000A, 32'h4180, 32'h3200, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h2400000B, 32'h4184, 32'h4180, 0, 0);
        addRow(0, 0, 0, 0, 2, 32'h3207, 32'h0, 32'h2400000C, 32'h3204, 32'h4184, 0, 0);
        // jr to a misaligned address raises ADEL in ID
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h03E00008, 32'h3208, 32'h3204, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h3302, 32'h2400000D, 32'h3302, 32'h3208, 0, 1);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h2400000E, 32'h3306, 32'h3302, 4, 0);
        addRow(0, 0, 0, 0, 2, 32'h3400, 32'h0, 32'h00000000, 32'h3400, 32'h3306, 4, 0);
        // j to the terminal word
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h0800105F, 32'h3404, 32'h3400, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h2400000F, 32'h417C, 32'h3404, 0, 1);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h24000010, 32'h417C, 32'h417C, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h00000000, 32'h417C, 32'h417C, 0, 0);
        addRow(0, 0, 0, 0, 0, 32'h0, 32'h0, 32'h00000000, 32'h417C, 32'h417C, 0, 0);
    endtask

    task automatic applyRow(input stepRow_t r);
        imem[refPc] = r.instr;
        memWrites++;
        stall   = r.stall;
        stallPc = r.stallPc;
        clr     = r.clr;
        cmp     = r.cmp;
        kCtrl   = r.kCtrl;
        epc     = r.epc;
        jmpReg  = (r.jmpReg == 32'h0) ? $urandom() : r.jmpReg;
    endtask

    // advance the reference pc and slot by one clock edge
    task automatic modelStep(input stepRow_t r);
        fetchPkg::addr_t       nextPc;
        fetchPkg::ifIdBundle_t nextSlot;
        nextPc = refNextPc(refPc, refSlot.code, r.cmp, jmpReg, r.kCtrl, r.epc);
        if (r.stallPc) begin
            nextPc = refPc;
        end
        nextSlot = refSlot;
        if (r.clr) begin
            nextSlot = '0;
        end else if (!r.stall) begin
            nextSlot.code = r.instr;
            nextSlot.pc   = refPc;
            nextSlot.exc  = excOf(refPc);
            nextSlot.bd   = (flowOf(refSlot.code) != fetchPkg::FLOW_ORDER);
        end
        refPc   = nextPc;
        refSlot = nextSlot;
    endtask

    initial begin
        stepRow_t r;
        void'($urandom(68));
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        stallPc   = 1'b0;
        clr       = 1'b0;
        cmp       = 1'b0;
        jmpReg    = 32'h0;
        kCtrl     = fetchPkg::KCTRL_NONE;
        epc       = 32'h0;
        imCode    = 32'h0;
        memWrites = 0;
        refPc     = `TEXT_START_ADDR;
        refSlot   = '0;
        buildTable();

        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        waitForPcIf(`TEXT_START_ADDR, 4);
        checkValue(imPc, `TEXT_START_ADDR, "imPc after reset");
        checkValue(pcId, 32'h0, "pcId after reset");
        checkValue(excId, 32'h0, "excId after reset");
        checkValue(bdId, 32'h0, "bdId after reset");

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            applyRow(r);
            modelStep(r);
            @(posedge clk);
            #10;
            checkValue(pcIf, r.expPcIf, $sformatf("row %0d pcIf", i));
            checkValue(imPc, r.expPcIf, $sformatf("row %0d imPc", i));
            checkValue(pcIf, refPc, $sformatf("row %0d pcIf against model", i));
            checkValue(pcId, r.expPcId, $sformatf("row %0d pcId", i));
            checkValue(excId, r.expExc, $sformatf("row %0d excId", i));
            checkValue(bdId, r.expBd, $sformatf("row %0d bdId", i));
            checkValue(codeId, refSlot.code, $sformatf("row %0d codeId", i));
            checkValue(bdIf, flowOf(refSlot.code) != fetchPkg::FLOW_ORDER,
                       $sformatf("row %0d bdIf", i));
        end

        // program stays parked on the terminal word
        waitForPcIf(`KTEXT_START_ADDR - 32'd4, 8);
        repeat (6) begin
            @(posedge clk);
            #10;
            checkValue(pcIf, `KTEXT_START_ADDR - 32'd4, "parked pcIf");
            checkValue(imPc, `KTEXT_START_ADDR - 32'd4, "parked imPc");
            checkValue(pcId, `KTEXT_START_ADDR - 32'd4, "parked pcId");
        end

        if (u_dut.u_checker.assertFails != 0) begin
            abortRun("bound assertions reported failures");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+src
src/fetchPkg.sv
src/instrClassifier.sv
src/nextPcUnit.sv
src/pcRegister.sv
src/ifIdRegister.sv
src/fetchTop.sv
verification/fetch_checker.sv
verification/fetchTb.sv
